//--- buffer_ctrl.sv
`timescale 1ns/1ns

module buffer_ctrl (
	input  logic sysclk,
	input  logic rst,
	input  logic frame_done,
	input  logic frame_loaded,
	output logic bank,
	output logic load_ready,
	output logic swap
);

	// load_ready low means a full frame waits in the back bank
	always_ff @(posedge sysclk) begin
		if (rst) begin
			bank <= 1'b0;
			load_ready <= 1'b1;
			swap <= 1'b0;
		end else begin
			swap <= 1'b0;
			if (frame_done && !load_ready) begin
				// flip only between scan frames, no tearing
				bank <= ~bank;
				load_ready <= 1'b1;
				swap <= 1'b1;
			end else if (load_ready && frame_loaded) begin
				load_ready <= 1'b0;
			end
		end
	end

endmodule

//--- frame_buffer.sv
`timescale 1ns/1ns
`include "matrix_consts.svh"

module frame_buffer (
	input  logic                   sysclk,
	input  logic                   wen,
	input  matrix_pkg::pix_addr_t  waddr,
	input  matrix_pkg::seg_pixel_t wdata,
	input  matrix_pkg::pix_addr_t  raddr,
	input  logic                   bank,
	output matrix_pkg::seg_pixel_t rdata
);
	import matrix_pkg::*;

	localparam int AW = `ROW_BITS + `COL_BITS;
	localparam int DEPTH = `ROWS * `COLUMNS;

	// two banks, bank picks the one on display
	seg_pixel_t mem [0:1][0:DEPTH-1];

	logic [AW-1:0] wa;
	logic [AW-1:0] ra;
	logic back_bank;

	assign wa = waddr;
	assign ra = raddr;
	assign back_bank = ~bank;

	// loader only ever touches the hidden bank
	always_ff @(posedge sysclk) begin
		if (wen)
			mem[back_bank][wa] <= wdata;
	end

	// one cycle read latency, scan engine fetches ahead
	always_ff @(posedge sysclk) begin
		rdata <= mem[bank][ra];
	end

endmodule

//--- frame_loader.sv
`timescale 1ns/1ns
`include "matrix_consts.svh"

module frame_loader (
	input  logic                   sysclk,
	input  logic                   rst,
	input  logic [7:0]             rx_data,
	input  logic                   rx_valid,
	input  logic                   load_ready,
	output logic                   wen,
	output matrix_pkg::pix_addr_t  waddr,
	output matrix_pkg::seg_pixel_t wdata,
	output logic                   frame_loaded
);
	import matrix_pkg::*;

	localparam int LANES = `SEGMENTS * 3;
	localparam int LW = $clog2(LANES);
	localparam int AW = `ROW_BITS + `COL_BITS;
	localparam int PW = $bits(seg_pixel_t);

	logic [LW-1:0] lane;
	seg_pixel_t asm_q;
	logic take;

	// bytes seen while not ready are lost and do not count
	assign take = rx_valid && load_ready;
	assign wdata = asm_q;

	// last pixel of the frame is being written
	assign frame_loaded = wen && (waddr.row == (`ROW_BITS)'(`ROWS - 1))
		&& (waddr.col == (`COL_BITS)'(`COLUMNS - 1));

	// first byte of a pixel ends up in seg0.r
	always_ff @(posedge sysclk) begin
		if (take)
			asm_q <= {asm_q[PW-9:0], rx_data};
	end

	always_ff @(posedge sysclk) begin
		if (rst) begin
			lane <= '0;
			wen <= 1'b0;
			waddr <= '0;
		end else begin
			wen <= take && (lane == LW'(LANES - 1));
			if (take)
				lane <= (lane == LW'(LANES - 1)) ? '0 : lane + 1'b1;
			// wraps to zero after the last pixel
			if (wen)
				waddr <= waddr + AW'(1);
		end
	end

endmodule

//--- hub75_scan.sv
`timescale 1ns/1ns
`include "matrix_consts.svh"

module hub75_scan (
	input  logic                   sysclk,
	input  logic                   rst,
	input  matrix_pkg::seg_pixel_t rdata,
	output matrix_pkg::pix_addr_t  raddr,
	output logic [5:0]             rgb,
	output logic [2:0]             a,
	output logic                   oclk,
	output logic                   lat,
	output logic                   oe,
	output logic                   frame_done
);
	import matrix_pkg::*;

	localparam int CW = `COL_BITS;
	localparam int RW = `ROW_BITS;
	localparam int PW = `PLANE_BITS;
	localparam int OW = $clog2(`PLANE_BASE) + `BITDEPTH;

	scan_state_e state;
	logic [CW-1:0] col_cnt;
	logic ph;
	logic [RW-1:0] row_cnt;
	logic [PW-1:0] plane;
	logic [OW-1:0] on_cnt;
	logic frame_end;

	// next column is requested while oclk is high
	assign raddr = '{row: row_cnt, col: col_cnt + CW'(ph)};

	// bank may flip on this pulse, NEXT then fetches from the new front
	assign frame_done = (state == SHOW) && (on_cnt == '0) && frame_end;

	// current plane bit of each channel, seg0 on the low bits
	always_comb begin
		rgb[0] = rdata.seg0.r[plane];
		rgb[1] = rdata.seg0.g[plane];
		rgb[2] = rdata.seg0.b[plane];
		rgb[3] = rdata.seg1.r[plane];
		rgb[4] = rdata.seg1.g[plane];
		rgb[5] = rdata.seg1.b[plane];
	end

	always_ff @(posedge sysclk) begin
		if (rst) begin
			state <= SHIFT;
			col_cnt <= '0;
			ph <= 1'b0;
			row_cnt <= '0;
			plane <= '0;
			on_cnt <= '0;
			frame_end <= 1'b0;
			oclk <= 1'b0;
			lat <= 1'b0;
			oe <= 1'b1;
			a <= '0;
		end else begin
			case (state)
				SHIFT: begin
					// one cycle low, one cycle high per column
					ph <= ~ph;
					oclk <= ~ph;
					if (ph) begin
						if (col_cnt == CW'(`COLUMNS - 1)) begin
							col_cnt <= '0;
							lat <= 1'b1;
							a <= row_cnt;
							state <= LATCH;
						end else begin
							col_cnt <= col_cnt + 1'b1;
						end
					end
				end
				LATCH: begin
					lat <= 1'b0;
					oe <= 1'b0;
					on_cnt <= (OW'(`PLANE_BASE) << plane) - OW'(1);
					frame_end <= (row_cnt == RW'(`ROWS - 1))
						&& (plane == PW'(`BITDEPTH - 1));
					// step row and plane early, SHOW already has its length
					if (row_cnt == RW'(`ROWS - 1)) begin
						row_cnt <= '0;
						plane <= (plane == PW'(`BITDEPTH - 1)) ? '0 : plane + 1'b1;
					end else begin
						row_cnt <= row_cnt + 1'b1;
					end
					state <= SHOW;
				end
				SHOW: begin
					if (on_cnt == '0) begin
						oe <= 1'b1;
						state <= NEXT;
					end else begin
						on_cnt <= on_cnt - 1'b1;
					end
				end
				NEXT: begin
					// prefetch slot for column 0 of the next row
					state <= SHIFT;
				end
			endcase
		end
	end

endmodule

//--- matrix_assertions.sv
`timescale 1ns/1ns

module matrix_assertions (
	input logic sysclk,
	input logic rst,
	input logic lat,
	input logic oe,
	input logic oclk,
	input logic load_ready,
	input logic frame_loaded
);

	// latching while lit would flash the next row's data
	lat_while_dark: assert property (@(posedge sysclk) disable iff (rst)
		!(lat && !oe))
		else $error("lat high while oe low");

	oclk_outside_latch: assert property (@(posedge sysclk) disable iff (rst)
		!(oclk && lat))
		else $error("oclk high while lat high");

	// ready only drops as the handshake completes
	ready_fall: assert property (@(posedge sysclk) disable iff (rst)
		$fell(load_ready) |-> $past(frame_loaded))
		else $error("load_ready fell without frame_loaded");

endmodule

// signals a module does not own are tied to their idle values
bind hub75_scan matrix_assertions scan_checks (
	.sysclk(sysclk),
	.rst(rst),
	.lat(lat),
	.oe(oe),
	.oclk(oclk),
	.load_ready(1'b1),
	.frame_loaded(1'b0)
);

bind buffer_ctrl matrix_assertions ctrl_checks (
	.sysclk(sysclk),
	.rst(rst),
	.lat(1'b0),
	.oe(1'b1),
	.oclk(1'b0),
	.load_ready(load_ready),
	.frame_loaded(frame_loaded)
);

//--- matrix_consts.svh
`ifndef MATRIX_CONSTS_SVH
`define MATRIX_CONSTS_SVH

// panel geometry, split into stacked halves
`define SEGMENTS 2
`define ROWS 8
`define COLUMNS 16
`define BITDEPTH 8

// derived address and plane widths
`define ROW_BITS ($clog2(`ROWS))
`define COL_BITS ($clog2(`COLUMNS))
`define PLANE_BITS ($clog2(`BITDEPTH))

// uart bit period in sysclk cycles
`define CLKS_PER_BIT 4

// on-time of plane 0, doubles per plane
`define PLANE_BASE 4

// reply sent once per bank swap
`define ACK_BYTE 8'he0

`endif

//--- matrix_pkg.sv
`include "matrix_consts.svh"

package matrix_pkg;

	// one colour sample
	typedef struct packed {
		logic [`BITDEPTH-1:0] r;
		logic [`BITDEPTH-1:0] g;
		logic [`BITDEPTH-1:0] b;
	} rgb_t;

	// memory word, upper segment in the high bits
	typedef struct packed {
		rgb_t seg0;
		rgb_t seg1;
	} seg_pixel_t;

	// col in the low bits so a plain increment walks row-major
	typedef struct packed {
		logic [`ROW_BITS-1:0] row;
		logic [`COL_BITS-1:0] col;
	} pix_addr_t;

	typedef enum logic [1:0] {SHIFT, LATCH, SHOW, NEXT} scan_state_e;

	typedef enum logic [1:0] {IDLE, START, DATA, STOP} uart_state_e;

endpackage

//--- matrix_top.sv
`timescale 1ns/1ns
`include "matrix_consts.svh"

module matrix_top (
	input  logic       sysclk,
	input  logic       rst,
	input  logic       uart_rxi,
	output logic       uart_txo,
	output logic       oclk,
	output logic       lat,
	output logic       oe,
	output logic [5:0] rgb,
	output logic [2:0] a
);
	import matrix_pkg::*;

	// receiver to loader
	logic [7:0] rx_data;
	logic rx_valid;

	// loader to buffer and control
	logic wen;
	pix_addr_t waddr;
	seg_pixel_t wdata;
	logic frame_loaded;
	logic load_ready;

	// scan side
	pix_addr_t raddr;
	seg_pixel_t rdata;
	logic frame_done;
	logic bank;
	logic swap;

	uart_rx uart_rx_inst (
		.sysclk(sysclk),
		.rst(rst),
		.rxi(uart_rxi),
		.rx_data(rx_data),
		.rx_valid(rx_valid)
	);

	frame_loader frame_loader_inst (
		.sysclk(sysclk),
		.rst(rst),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.load_ready(load_ready),
		.wen(wen),
		.waddr(waddr),
		.wdata(wdata),
		.frame_loaded(frame_loaded)
	);

	frame_buffer frame_buffer_inst (
		.sysclk(sysclk),
		.wen(wen),
		.waddr(waddr),
		.wdata(wdata),
		.raddr(raddr),
		.bank(bank),
		.rdata(rdata)
	);

	buffer_ctrl buffer_ctrl_inst (
		.sysclk(sysclk),
		.rst(rst),
		.frame_done(frame_done),
		.frame_loaded(frame_loaded),
		.bank(bank),
		.load_ready(load_ready),
		.swap(swap)
	);

	hub75_scan hub75_scan_inst (
		.sysclk(sysclk),
		.rst(rst),
		.rdata(rdata),
		.raddr(raddr),
		.rgb(rgb),
		.a(a),
		.oclk(oclk),
		.lat(lat),
		.oe(oe),
		.frame_done(frame_done)
	);

	// ack on every swap, busy not needed at this frame rate
	uart_tx uart_tx_inst (
		.sysclk(sysclk),
		.rst(rst),
		.start(swap),
		.tx_data(`ACK_BYTE),
		.txo(uart_txo),
		.busy()
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the matrix testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_matrix -o tb_matrix
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_matrix > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
	exit 1
fi
exit 0

//--- tb_matrix.sv
`timescale 1ns/1ns
`include "matrix_consts.svh"

module tb_matrix;

	localparam int LANES = `SEGMENTS * 3;
	localparam int FRAME_BYTES = `ROWS * `COLUMNS * LANES;
	// one scan frame, shift and latch per row plus the weighted on-times
	localparam int SCAN_CYCLES = `ROWS * (`BITDEPTH * (2 * `COLUMNS + 2)
		+ `PLANE_BASE * ((1 << `BITDEPTH) - 1));
	// three uart frames, plus room for the swaps and the last display checks
	localparam int TIMEOUT = 3 * FRAME_BYTES * 10 * `CLKS_PER_BIT + 10 * SCAN_CYCLES;

	logic sysclk = 1'b0;
	logic rst = 1'b1;
	logic uart_rxi = 1'b1;
	logic uart_txo;
	logic oclk;
	logic lat;
	logic oe;
	logic [5:0] rgb;
	logic [2:0] a;

	integer seed;
	int errors = 0;
	int checks = 0;
	int pixel_checks = 0;
	int cycles = 0;

	// shadow frames, one byte per entry in uart order
	logic [7:0] front [0:FRAME_BYTES-1];
	logic [7:0] back [0:FRAME_BYTES-1];
	int acks = 0;
	int wraps = 0;
	logic check_on = 1'b0;

	// scan position deduced from the lat pulses
	int mon_row = 0;
	int mon_plane = 0;
	int col_seen = 0;
	int show_plane = 0;
	int oe_len = 0;
	logic in_show = 1'b0;
	logic [5:0] exp_rgb;

	matrix_top matrix_top_inst (
		.sysclk(sysclk),
		.rst(rst),
		.uart_rxi(uart_rxi),
		.uart_txo(uart_txo),
		.oclk(oclk),
		.lat(lat),
		.oe(oe),
		.rgb(rgb),
		.a(a)
	);

	always #2 sysclk = ~sysclk;

	task automatic check(input int got, input int expected, input string what);
		checks++;
		if (got != expected) begin
			errors++;
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	// start bit, eight data bits lsb first, stop bit
	task automatic send_byte(input logic [7:0] value);
		logic [9:0] bits;
		bits = {1'b1, value, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_rxi = bits[i];
			repeat (`CLKS_PER_BIT) @(posedge sysclk);
			#1;
		end
	endtask

	task automatic send_frame(input int extra);
		int rnd;
		int start_wraps;
		logic [7:0] value;
		@(posedge sysclk);
		#1;
		for (int i = 0; i < FRAME_BYTES + extra; i++) begin
			rnd = $random(seed);
			value = rnd[7:0];
			if (i == FRAME_BYTES - 1 && extra > 0) begin
				// finish at a scan frame start so the extra bytes beat the swap
				start_wraps = wraps;
				wait (wraps != start_wraps);
				@(posedge sysclk);
				#1;
			end
			// bytes past the frame end are expected to be dropped
			if (i < FRAME_BYTES)
				back[i] = value;
			send_byte(value);
		end
	endtask

	initial begin : ack_receiver
		logic [7:0] ack_byte;
		wait (rst === 1'b0);
		forever begin
			@(negedge uart_txo);
			// new bank already on display, shadow follows after the decode
			check_on = 1'b0;
			repeat (2) @(negedge sysclk);
			check(uart_txo, 0, "ack start bit");
			for (int i = 0; i < 8; i++) begin
				repeat (`CLKS_PER_BIT) @(negedge sysclk);
				ack_byte[i] = uart_txo;
			end
			repeat (`CLKS_PER_BIT) @(negedge sysclk);
			check(uart_txo, 1, "ack stop bit");
			check(ack_byte, `ACK_BYTE, "ack byte");
			for (int i = 0; i < FRAME_BYTES; i++)
				front[i] = back[i];
			acks++;
		end
	end

	// outputs sampled mid cycle, away from the clock edge
	always @(negedge sysclk) begin
		if (!rst) begin
			if (oclk) begin
				if (check_on) begin
					for (int k = 0; k < LANES; k++)
						exp_rgb[k] = front[(mon_row * `COLUMNS + col_seen) * LANES + k][mon_plane];
					check(rgb, exp_rgb, "rgb");
					pixel_checks++;
				end
				col_seen++;
			end
			if (lat) begin
				check(a, mon_row, "row address at lat");
				check(col_seen, `COLUMNS, "oclk pulses per row");
				col_seen = 0;
				show_plane = mon_plane;
				in_show = 1'b1;
				if (mon_row == `ROWS - 1) begin
					mon_row = 0;
					if (mon_plane == `BITDEPTH - 1) begin
						mon_plane = 0;
						// next scan frame shows whatever the last ack announced
						check_on = (acks > 0);
						wraps++;
					end else begin
						mon_plane++;
					end
				end else begin
					mon_row++;
				end
			end
			if (!oe) begin
				check(in_show, 1, "oe low outside show");
				oe_len++;
			end else if (oe_len > 0) begin
				check(oe_len, `PLANE_BASE << show_plane, "oe low time");
				oe_len = 0;
				in_show = 1'b0;
			end
		end
	end

	always @(posedge sysclk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		int end_wraps;
		seed = 32'h9fe4;
		repeat (5) @(posedge sysclk);
		#1;
		check(oe, 1, "oe in reset");
		check(lat, 0, "lat in reset");
		check(oclk, 0, "oclk in reset");
		check(uart_txo, 1, "txo in reset");
		rst = 1'b0;
		send_frame(0);
		wait (acks == 1);
		// second frame loads while the first stays on display
		send_frame(6);
		wait (acks == 2);
		send_frame(0);
		wait (acks == 3);
		end_wraps = wraps + 2;
		wait (wraps >= end_wraps);
		check(pixel_checks > 0, 1, "pixels compared");
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- uart_rx.sv
`timescale 1ns/1ns
`include "matrix_consts.svh"

module uart_rx (
	input  logic       sysclk,
	input  logic       rst,
	input  logic       rxi,
	output logic [7:0] rx_data,
	output logic       rx_valid
);
	import matrix_pkg::*;

	localparam int CW = $clog2(`CLKS_PER_BIT) + 1;
	localparam logic [CW-1:0] HALF = CW'(`CLKS_PER_BIT / 2 - 1);
	localparam logic [CW-1:0] FULL = CW'(`CLKS_PER_BIT - 1);

	uart_state_e state;
	logic [CW-1:0] cnt;
	logic [2:0] bit_idx;
	logic [7:0] shreg;
	logic rx_meta;
	logic rx_sync;

	always_ff @(posedge sysclk) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			state <= IDLE;
			cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_meta <= rxi;
			rx_sync <= rx_meta;
			rx_valid <= 1'b0;
			case (state)
				IDLE: begin
					cnt <= '0;
					if (!rx_sync)
						state <= START;
				end
				START: begin
					// recheck at mid start bit, a glitch goes back to idle
					if (cnt == HALF) begin
						cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? IDLE : DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				DATA: begin
					if (cnt == FULL) begin
						cnt <= '0;
						// lsb first
						shreg <= {rx_sync, shreg[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= STOP;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				STOP: begin
					if (cnt == FULL) begin
						// framing error drops the byte
						if (rx_sync) begin
							rx_data <= shreg;
							rx_valid <= 1'b1;
						end
						state <= IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ns
`include "matrix_consts.svh"

module uart_tx (
	input  logic       sysclk,
	input  logic       rst,
	input  logic       start,
	input  logic [7:0] tx_data,
	output logic       txo,
	output logic       busy
);
	import matrix_pkg::*;

	localparam int CW = $clog2(`CLKS_PER_BIT) + 1;
	localparam logic [CW-1:0] FULL = CW'(`CLKS_PER_BIT - 1);

	uart_state_e state;
	logic [CW-1:0] cnt;
	logic [2:0] bit_idx;
	logic [7:0] shreg;

	assign busy = (state != IDLE);

	always_ff @(posedge sysclk) begin
		if (rst) begin
			state <= IDLE;
			cnt <= '0;
			bit_idx <= '0;
			txo <= 1'b1;
		end else begin
			case (state)
				IDLE: begin
					cnt <= '0;
					// requests only taken here, so a busy frame ignores them
					if (start) begin
						shreg <= tx_data;
						txo <= 1'b0;
						state <= START;
					end
				end
				START: begin
					if (cnt == FULL) begin
						cnt <= '0;
						bit_idx <= '0;
						txo <= shreg[0];
						state <= DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				DATA: begin
					if (cnt == FULL) begin
						cnt <= '0;
						if (bit_idx == 3'd7) begin
							txo <= 1'b1;
							state <= STOP;
						end else begin
							txo <= shreg[1];
							shreg <= shreg >> 1;
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				STOP: begin
					if (cnt == FULL)
						state <= IDLE;
					else
						cnt <= cnt + 1'b1;
				end
			endcase
		end
	end

endmodule

//--- verilog.f
+incdir+.
matrix_pkg.sv
uart_rx.sv
uart_tx.sv
frame_loader.sv
frame_buffer.sv
buffer_ctrl.sv
hub75_scan.sv
matrix_top.sv
matrix_assertions.sv
tb_matrix.sv
